// ==== crc_ahb.f ====
rtl/crc_pkg.sv
rtl/crc_host_if.sv
rtl/crc_data_buffer.sv
rtl/crc_input_reflect.sv
rtl/crc_engine.sv
rtl/crc_ahb_top.sv
dv/crc_ahb_tb.sv

// ==== Makefile ====
# Verilator build and run of the AHB-Lite CRC accelerator testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert --top-module crc_ahb_tb \
		-f crc_ahb.f -Mdir obj_dir -o crc_ahb_sim
	./obj_dir/crc_ahb_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/crc_ahb_tb.sv ====
/*
 * Testbench of the AHB-Lite CRC accelerator
 *   Clock, reset and AHB-Lite transfer tasks
 *   Reference CRC model with input and output reflection
 *   Comparing process for register and DR reads
 *   Cycle limit and closing summary
 */
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_tb
	import crc_pkg::*;
();

	// Planned transfers per test, sets the cycle limit
	localparam int XFERS_RESET   = 16;
	localparam int XFERS_CRC32   = 21;
	localparam int XFERS_SIZES   = 48;
	localparam int XFERS_REFLECT = 66;
	localparam int XFERS_BURST   = 18;
	localparam int XFERS_CHAIN   = 21;
	localparam int XFER_TOTAL    = XFERS_RESET + XFERS_CRC32 + XFERS_SIZES +
	                               XFERS_REFLECT + XFERS_BURST + XFERS_CHAIN;
	localparam int CYCLE_LIMIT   = 20 * XFER_TOTAL;

	logic       HCLK;
	logic       HRESETn;
	logic       HSElx;
	word_t      HADDR;
	logic [1:0] HTRANS;
	logic [2:0] HSIZE;
	logic       HWRITE;
	word_t      HWDATA;
	logic       HREADY;
	word_t      HRDATA;
	logic       HREADYOUT;
	logic       HRESP;

	integer seed = 32'h1f31;

	// Reference state of the accelerator
	word_t    exp_crc;
	word_t    mod_init;
	word_t    mod_poly;
	crc_cfg_t mod_cfg;

	int checks;
	int errors;
	int checks_mark;
	int errors_mark;
	int stall_cycles;
	int cycles;

	// Reads waiting for comparison
	word_t got_q[$];
	word_t exp_q[$];
	string name_q[$];
	time   time_q[$];
	word_t cmp_got;
	word_t cmp_exp;
	string cmp_name;
	time   cmp_time;

	crc_ahb_top DUT (
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSElx     (HSElx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	initial
	begin
		HCLK = 1'b0;
		forever
			#10 HCLK = ~HCLK;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic int poly_width(input poly_size_t code);
		case (code)
			2'd1:    return 16;
			2'd2:    return 8;
			2'd3:    return 7;
			default: return 32;
		endcase
	endfunction

	function automatic word_t width_mask(input int w);
		if (w == 32)
			return 32'hFFFF_FFFF;
		return (32'h1 << w) - 32'h1;
	endfunction

	// Mirror of the low w bits
	function automatic word_t reverse_bits(input word_t value, input int w);
		word_t result;
		result = '0;
		for (int i = 0; i < w; i++)
			result[i] = value[w - 1 - i];
		return result;
	endfunction

	// Word mirror, then swap lanes back for per-byte and per-halfword
	function automatic word_t reflect_input(input word_t data, input rev_in_t mode);
		word_t r;
		r = reverse_bits(data, 32);
		case (mode)
			2'd1:    return {r[7:0], r[15:8], r[23:16], r[31:24]};
			2'd2:    return {r[15:0], r[31:16]};
			2'd3:    return r;
			default: return data;
		endcase
	endfunction

	// Folds one write into the raw CRC, top byte first, MSB first
	function automatic word_t crc_model(input word_t crc, input word_t data,
	                                    input xfer_size_t size, input word_t poly,
	                                    input crc_cfg_t cfg);
		word_t mask;
		word_t d;
		word_t c;
		int    w;
		int    nbytes;
		logic  fb;
		w      = poly_width(cfg.poly_size);
		mask   = width_mask(w);
		d      = reflect_input(data, cfg.rev_in);
		nbytes = (size == 2'd0) ? 1 : ((size == 2'd1) ? 2 : 4);
		c      = crc & mask;
		for (int k = nbytes - 1; k >= 0; k--)
		begin
			for (int j = 7; j >= 0; j--)
			begin
				fb = c[w - 1] ^ d[k * 8 + j];
				c  = (c << 1) & mask;
				if (fb)
					c = c ^ (poly & mask);
			end
		end
		return c;
	endfunction

	// DR read value seen by the host
	function automatic word_t dr_view(input word_t crc, input crc_cfg_t cfg);
		int w;
		w = poly_width(cfg.poly_size);
		if (cfg.rev_out)
			return reverse_bits(crc & width_mask(w), w);
		return crc & width_mask(w);
	endfunction

	//////////////////////////////////////////////////
	// AHB-Lite transfers
	//////////////////////////////////////////////////

	// Returns at the falling edge before the completing rising edge
	task automatic wait_ready();
		@(negedge HCLK);
		while (!HREADYOUT)
		begin
			stall_cycles++;
			@(negedge HCLK);
		end
	endtask

	task automatic bus_xfer(input logic write, input logic [2:0] ofs, input xfer_size_t size,
	                        input word_t wdata, output word_t rdata);
		@(posedge HCLK);
		HSElx  <= 1'b1;
		HADDR  <= {27'h0, ofs, 2'b00};
		HTRANS <= HTRANS_NONSEQ;
		HWRITE <= write;
		HSIZE  <= {1'b0, size};
		wait_ready();
		// Address sampled here, data phase follows
		@(posedge HCLK);
		HSElx  <= 1'b0;
		HTRANS <= 2'b00;
		HWDATA <= wdata;
		wait_ready();
		rdata = HRDATA;
	endtask

	task automatic write_reg(input logic [2:0] ofs, input word_t data);
		word_t unused;
		bus_xfer(1'b1, ofs, 2'd2, data, unused);
	endtask

	// Queues a read for the comparing process
	task automatic check_reg(input string name, input logic [2:0] ofs, input word_t expected);
		word_t rdata;
		bus_xfer(1'b0, ofs, 2'd2, '0, rdata);
		got_q.push_back(rdata);
		exp_q.push_back(expected);
		name_q.push_back(name);
		time_q.push_back($time);
	endtask

	task automatic write_dr(input xfer_size_t size);
		word_t data;
		word_t unused;
		data = $random(seed);
		bus_xfer(1'b1, ADDR_DR, size, data, unused);
		exp_crc = crc_model(exp_crc, data, size, mod_poly, mod_cfg);
	endtask

	// Word writes with no idle cycle, address held while stalled
	task automatic dr_burst(input int count);
		word_t words[$];
		for (int i = 0; i < count; i++)
			words.push_back($random(seed));
		@(posedge HCLK);
		HSElx  <= 1'b1;
		HADDR  <= {27'h0, ADDR_DR, 2'b00};
		HTRANS <= HTRANS_NONSEQ;
		HWRITE <= 1'b1;
		HSIZE  <= 3'd2;
		for (int i = 0; i < count; i++)
		begin
			wait_ready();
			@(posedge HCLK);
			HWDATA <= words[i];
			if (i == count - 1)
			begin
				HSElx  <= 1'b0;
				HTRANS <= 2'b00;
			end
			exp_crc = crc_model(exp_crc, words[i], 2'd2, mod_poly, mod_cfg);
		end
		wait_ready();
	endtask

	// CR write, bit 0 requests a chain reset
	task automatic set_cfg(input crc_cfg_t cfg, input logic chain);
		write_reg(ADDR_CR, {24'h0, cfg, 2'b00, chain});
		mod_cfg = cfg;
		if (chain)
			exp_crc = mod_init;
	endtask

	// INIT write also restarts the running CRC
	task automatic set_init(input word_t value);
		write_reg(ADDR_INIT, value);
		mod_init = value;
		exp_crc  = value;
	endtask

	task automatic set_poly(input word_t value);
		write_reg(ADDR_POL, value);
		mod_poly = value;
	endtask

	task automatic begin_test();
		checks_mark = checks;
		errors_mark = errors;
	endtask

	task automatic end_test(input string name);
		while (got_q.size() != 0)
			@(negedge HCLK);
		$display("[test] %-16s %0d checks, %0d failed", name,
		         checks - checks_mark, errors - errors_mark);
	endtask

	//////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////

	always @(posedge HCLK)
	begin
		while (got_q.size() != 0)
		begin
			cmp_got  = got_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			cmp_name = name_q.pop_front();
			cmp_time = time_q.pop_front();
			checks++;
			assert (cmp_got == cmp_exp)
			else
			begin
				$display("CHECK FAILED at %0t: %s got %h expected %h",
				         cmp_time, cmp_name, cmp_got, cmp_exp);
				errors++;
			end
		end
	end

	// OKAY response only
	always @(negedge HCLK)
	begin
		if (HRESETn)
		begin
			assert (HRESP == 1'b0)
			else
			begin
				$display("CHECK FAILED at %0t: HRESP got %b expected 0", $time, HRESP);
				errors++;
			end
		end
	end

	// Hang guard
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge HCLK);
			cycles++;
		end
		$display("Bus hang: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("ERRORS FOUND");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		crc_cfg_t cfg;
		int       stalls;
		checks       = 0;
		errors       = 0;
		stall_cycles = 0;
		HRESETn <= 1'b0;
		HSElx   <= 1'b0;
		HADDR   <= '0;
		HTRANS  <= 2'b00;
		HSIZE   <= 3'd2;
		HWRITE  <= 1'b0;
		HWDATA  <= '0;
		// No other slave can stretch a transfer
		HREADY  <= 1'b1;
		repeat (10) @(posedge HCLK);
		HRESETn <= 1'b1;
		mod_init = RESET_INIT;
		mod_poly = RESET_POLY;
		mod_cfg  = RESET_CR;
		exp_crc  = RESET_INIT;

		// Reset values and register read-back
		begin_test();
		check_reg("HRDATA(CR)", ADDR_CR, 32'h0);
		check_reg("HRDATA(IDR)", ADDR_IDR, 32'h0);
		check_reg("HRDATA(INIT)", ADDR_INIT, 32'hFFFF_FFFF);
		check_reg("HRDATA(POL)", ADDR_POL, 32'h04C1_1DB7);
		check_reg("HRDATA(DR)", ADDR_DR, 32'hFFFF_FFFF);
		write_reg(ADDR_IDR, 32'h5A5A_C3C3);
		check_reg("HRDATA(IDR)", ADDR_IDR, 32'h0000_00C3);
		write_reg(ADDR_POL, 32'h0000_8005);
		check_reg("HRDATA(POL)", ADDR_POL, 32'h0000_8005);
		write_reg(ADDR_INIT, 32'h1234_5678);
		check_reg("HRDATA(INIT)", ADDR_INIT, 32'h1234_5678);
		write_reg(ADDR_CR, 32'hFFFF_FFFF);
		check_reg("HRDATA(CR)", ADDR_CR, 32'h0000_00F8);
		set_cfg(RESET_CR, 1'b0);
		set_init(RESET_INIT);
		set_poly(RESET_POLY);
		end_test("reset_values");

		// CRC-32 with the reset configuration
		begin_test();
		for (int i = 0; i < 20; i++)
			write_dr(2'd2);
		check_reg("HRDATA(DR)", ADDR_DR, dr_view(exp_crc, mod_cfg));
		end_test("default_crc32");

		// Narrow polynomials, junk above the width is masked
		begin_test();
		for (int s = 1; s < 4; s++)
		begin
			cfg           = RESET_CR;
			cfg.poly_size = poly_size_t'(s);
			set_poly((s == 1) ? 32'hA5A5_1021 : ((s == 2) ? 32'h0000_FF07 : 32'h0000_0009));
			set_init($random(seed));
			set_cfg(cfg, 1'b1);
			for (int i = 0; i < 12; i++)
				write_dr(xfer_size_t'(i % 3));
			check_reg("HRDATA(DR)", ADDR_DR, dr_view(exp_crc, mod_cfg));
		end
		end_test("poly_sizes");

		// All input reflection modes with output reflection off and on
		begin_test();
		set_poly(RESET_POLY);
		set_init(RESET_INIT);
		for (int m = 0; m < 8; m++)
		begin
			cfg         = RESET_CR;
			cfg.rev_in  = rev_in_t'(m >> 1);
			cfg.rev_out = m[0];
			set_cfg(cfg, 1'b1);
			for (int i = 0; i < 6; i++)
				write_dr(2'd2);
			check_reg("HRDATA(DR)", ADDR_DR, dr_view(exp_crc, mod_cfg));
		end
		end_test("reflection");

		// Back-to-back writes overrun the two-entry buffer
		begin_test();
		set_cfg(RESET_CR, 1'b1);
		stall_cycles = 0;
		dr_burst(16);
		stalls = stall_cycles;
		check_reg("HRDATA(DR)", ADDR_DR, dr_view(exp_crc, mod_cfg));
		checks++;
		assert (stalls > 0)
		else
		begin
			$display("Back-pressure missing: the DR burst never stalled the bus");
			errors++;
		end
		end_test("back_pressure");

		// Chain reset behind queued writes, then a new INIT
		begin_test();
		dr_burst(6);
		set_cfg(mod_cfg, 1'b1);
		check_reg("HRDATA(DR)", ADDR_DR, dr_view(mod_init, mod_cfg));
		dr_burst(6);
		set_cfg(mod_cfg, 1'b1);
		set_init(32'h89AB_CDEF);
		for (int i = 0; i < 4; i++)
			write_dr(2'd2);
		check_reg("HRDATA(DR)", ADDR_DR, dr_view(exp_crc, mod_cfg));
		end_test("chain_reset");

		$display("Summary: %0d checks, %0d failed", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/crc_ahb_top.sv ====
/*
 * Top level of the AHB-Lite CRC accelerator
 *   Host interface, data buffer, input reflection, CRC engine
 */
`timescale 1ns/1ps
`default_nettype none

module crc_ahb_top
	import crc_pkg::*;
(
	input  wire logic       HCLK,
	input  wire logic       HRESETn,
	input  wire logic       HSElx,
	input  wire word_t      HADDR,
	input  wire logic [1:0] HTRANS,
	input  wire logic [2:0] HSIZE,
	input  wire logic       HWRITE,
	input  wire word_t      HWDATA,
	input  wire logic       HREADY,
	output word_t           HRDATA,
	output logic            HREADYOUT,
	output logic            HRESP
);

	// Host to buffer
	data_item_t wr_item;
	logic       buffer_write_en;
	logic       buffer_full;
	// Buffer to reflect stage
	data_item_t buf_item;
	logic       buf_valid;
	logic       buf_pop;
	// Reflect stage to engine
	data_item_t refl_item;
	logic       refl_valid;
	logic       eng_ready;
	// Host to engine and back
	crc_cfg_t   cfg;
	word_t      bus_wr;
	logic       crc_init_en;
	logic       crc_poly_en;
	logic       reset_chain;
	word_t      crc_out;
	word_t      crc_init_out;
	word_t      crc_poly_out;
	logic       reset_pending;
	logic       read_wait;

	crc_host_if u_host_if (
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSElx           (HSElx),
		.HADDR           (HADDR),
		.HTRANS          (HTRANS),
		.HSIZE           (HSIZE),
		.HWRITE          (HWRITE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.crc_out         (crc_out),
		.crc_init_out    (crc_init_out),
		.crc_poly_out    (crc_poly_out),
		.buffer_full     (buffer_full),
		.reset_pending   (reset_pending),
		.read_wait       (read_wait),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.wr_item         (wr_item),
		.buffer_write_en (buffer_write_en),
		.bus_wr          (bus_wr),
		.cfg             (cfg),
		.crc_init_en     (crc_init_en),
		.crc_poly_en     (crc_poly_en),
		.reset_chain     (reset_chain)
	);

	crc_data_buffer u_data_buffer (
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.wr_item         (wr_item),
		.buffer_write_en (buffer_write_en),
		.buf_pop         (buf_pop),
		.buf_item        (buf_item),
		.buf_valid       (buf_valid),
		.buffer_full     (buffer_full)
	);

	crc_input_reflect u_input_reflect (
		.HCLK       (HCLK),
		.HRESETn    (HRESETn),
		.buf_item   (buf_item),
		.buf_valid  (buf_valid),
		.rev_in     (cfg.rev_in),
		.eng_ready  (eng_ready),
		.buf_pop    (buf_pop),
		.refl_item  (refl_item),
		.refl_valid (refl_valid)
	);

	crc_engine u_engine (
		.HCLK          (HCLK),
		.HRESETn       (HRESETn),
		.refl_item     (refl_item),
		.refl_valid    (refl_valid),
		.cfg           (cfg),
		.bus_wr        (bus_wr),
		.crc_init_en   (crc_init_en),
		.crc_poly_en   (crc_poly_en),
		.reset_chain   (reset_chain),
		.buf_valid     (buf_valid),
		.buffer_full   (buffer_full),
		.eng_ready     (eng_ready),
		.crc_out       (crc_out),
		.crc_init_out  (crc_init_out),
		.crc_poly_out  (crc_poly_out),
		.reset_pending (reset_pending),
		.read_wait     (read_wait)
	);

endmodule

`default_nettype wire

// ==== rtl/crc_engine.sv ====
/*
 * Byte-serial CRC engine
 *   POL, INIT and CRC registers
 *   FSM folding one byte per cycle, MSB first, at the chosen width
 *   Deferred chain reset behind data already in flight
 *   Output reflection and read wait flag
 */
`timescale 1ns/1ps
`default_nettype none

module crc_engine
	import crc_pkg::*;
(
	input  wire logic       HCLK,
	input  wire logic       HRESETn,
	input  wire data_item_t refl_item,
	input  wire logic       refl_valid,
	input  wire crc_cfg_t   cfg,
	input  wire word_t      bus_wr,
	input  wire logic       crc_init_en,
	input  wire logic       crc_poly_en,
	input  wire logic       reset_chain,
	input  wire logic       buf_valid,
	input  wire logic       buffer_full,
	output logic            eng_ready,
	output word_t           crc_out,
	output word_t           crc_init_out,
	output word_t           crc_poly_out,
	output logic            reset_pending,
	output logic            read_wait
);

	engine_state_t state;
	word_t         crc_q;
	word_t         shift_data;
	logic [1:0]    byte_idx;
	// Items that were written before the pending chain reset
	logic [2:0]    items_ahead;
	logic [2:0]    in_flight;
	logic          item_done;
	logic          reload_due;
	logic [4:0]    width_shift;
	byte_t         cur_byte;
	word_t         acc;
	word_t         poly_al;
	word_t         crc_next;
	word_t         crc_rev;

	// Left shift that puts a narrow CRC at the top of the word
	always_comb
	begin
		case (cfg.poly_size)
			2'd1:    width_shift = 5'd16;
			2'd2:    width_shift = 5'd24;
			2'd3:    width_shift = 5'd25;
			default: width_shift = 5'd0;
		endcase
	end

	//////////////////////////////////////////////////
	// Byte fold
	//////////////////////////////////////////////////

	assign cur_byte = shift_data[{byte_idx, 3'b000} +: 8];

	// Shifting out the top bits also masks POL to the width
	always_comb
	begin
		poly_al = crc_poly_out << width_shift;
		acc     = (crc_q << width_shift) ^ {cur_byte, 24'h0};
		for (int b = 0; b < 8; b++)
			acc = acc[31] ? ((acc << 1) ^ poly_al) : (acc << 1);
		crc_next = acc >> width_shift;
	end

	// Output reflection over the polynomial width only
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			crc_rev[i] = crc_q[31 - i];
		if (cfg.rev_out)
			crc_out = crc_rev >> width_shift;
		else
			crc_out = crc_q & (32'hFFFF_FFFF >> width_shift);
	end

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	assign item_done = (state == ENG_SHIFT) && (byte_idx == 2'd0);
	// Buffer holds two when full, reflect stage and engine one each
	assign in_flight = {1'b0, buffer_full, buf_valid && !buffer_full} +
	                   {2'b0, refl_valid} + {2'b0, state == ENG_SHIFT};
	assign reload_due = reset_pending && (items_ahead == 3'd0);
	assign eng_ready  = (state == ENG_IDLE) && !reload_due;
	assign read_wait  = buf_valid || refl_valid || (state != ENG_IDLE) || reset_pending;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state         <= ENG_IDLE;
			crc_q         <= RESET_INIT;
			crc_init_out  <= RESET_INIT;
			crc_poly_out  <= RESET_POLY;
			reset_pending <= 1'b0;
			items_ahead   <= '0;
			byte_idx      <= '0;
		end
		else
		begin
			case (state)
				ENG_IDLE:
				begin
					if (reload_due)
						state <= ENG_RELOAD;
					else if (refl_valid)
					begin
						state <= ENG_SHIFT;
						// Start at the top byte, word 3, halfword 1, byte 0
						if (refl_item.size == 2'd0)
							byte_idx <= 2'd0;
						else if (refl_item.size == 2'd1)
							byte_idx <= 2'd1;
						else
							byte_idx <= 2'd3;
					end
				end
				ENG_SHIFT:
				begin
					crc_q <= crc_next;
					if (item_done)
						state <= ENG_IDLE;
					else
						byte_idx <= byte_idx - 1'b1;
				end
				ENG_RELOAD:
				begin
					crc_q         <= crc_init_out;
					reset_pending <= 1'b0;
					state         <= ENG_IDLE;
				end
				default: state <= ENG_IDLE;
			endcase

			// A new chain reset counts everything still in the pipe
			if (reset_chain)
			begin
				reset_pending <= 1'b1;
				items_ahead   <= in_flight - {2'b0, item_done};
			end
			else if (reset_pending && item_done)
				items_ahead <= items_ahead - 1'b1;

			// INIT write also restarts the running CRC
			if (crc_init_en)
			begin
				crc_init_out <= bus_wr;
				crc_q        <= bus_wr;
			end
			if (crc_poly_en)
				crc_poly_out <= bus_wr;
		end
	end

	// Item data captured on acceptance
	always_ff @(posedge HCLK)
	begin
		if (eng_ready && refl_valid)
			shift_data <= refl_item.data;
	end

endmodule

`default_nettype wire

// ==== rtl/crc_input_reflect.sv ====
/*
 * Input reflection stage
 *   Bit reversal per byte, per halfword or over the word
 *   One-entry pipeline register with valid/ready handshake
 */
`timescale 1ns/1ps
`default_nettype none

module crc_input_reflect
	import crc_pkg::*;
(
	input  wire logic       HCLK,
	input  wire logic       HRESETn,
	input  wire data_item_t buf_item,
	input  wire logic       buf_valid,
	input  wire rev_in_t    rev_in,
	input  wire logic       eng_ready,
	output logic            buf_pop,
	output data_item_t      refl_item,
	output logic            refl_valid
);

	logic       accept;
	data_item_t flipped;

	// Room when empty or when the engine takes the item now
	assign accept  = !refl_valid || eng_ready;
	assign buf_pop = buf_valid && accept;

	always_comb
	begin
		flipped.size = buf_item.size;
		for (int i = 0; i < 32; i++)
		begin
			case (rev_in)
				2'd1:    flipped.data[i] = buf_item.data[(i / 8) * 8 + 7 - (i % 8)];
				2'd2:    flipped.data[i] = buf_item.data[(i / 16) * 16 + 15 - (i % 16)];
				2'd3:    flipped.data[i] = buf_item.data[31 - i];
				default: flipped.data[i] = buf_item.data[i];
			endcase
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			refl_valid <= 1'b0;
		else if (accept)
			refl_valid <= buf_valid;
	end

	// Payload moves only on a pop
	always_ff @(posedge HCLK)
	begin
		if (buf_pop)
			refl_item <= flipped;
	end

endmodule

`default_nettype wire

// ==== rtl/crc_data_buffer.sv ====
/*
 * Two-entry FIFO of DR write items
 *   Circular storage with read and write pointers
 *   Occupancy count, valid and full flags
 */
`timescale 1ns/1ps
`default_nettype none

module crc_data_buffer
	import crc_pkg::*;
(
	input  wire logic       HCLK,
	input  wire logic       HRESETn,
	input  wire data_item_t wr_item,
	input  wire logic       buffer_write_en,
	input  wire logic       buf_pop,
	output data_item_t      buf_item,
	output logic            buf_valid,
	output logic            buffer_full
);

	data_item_t mem [BUF_DEPTH];

	logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
	logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
	// Needs one more bit than the pointers to tell full from empty
	logic [1:0] count;

	// Pointers and occupancy
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (buffer_write_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (buf_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			if (buffer_write_en && !buf_pop)
				count <= count + 1'b1;
			else if (!buffer_write_en && buf_pop)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge HCLK)
	begin
		if (buffer_write_en)
			mem[wr_ptr] <= wr_item;
	end

	// Head of queue is always presented
	assign buf_item    = mem[rd_ptr];
	assign buf_valid   = (count != 2'd0);
	assign buffer_full = (count == 2'(BUF_DEPTH));

endmodule

`default_nettype wire

// ==== rtl/crc_host_if.sv ====
/*
 * AHB-Lite slave of the CRC accelerator
 *   Address phase pipeline registers
 *   Register decode and write enables
 *   CR and IDR registers, read data mux
 *   Wait states for full buffer, busy pipeline and pending reload
 */
`timescale 1ns/1ps
`default_nettype none

module crc_host_if
	import crc_pkg::*;
(
	input  wire logic        HCLK,
	input  wire logic        HRESETn,
	input  wire logic        HSElx,
	input  wire word_t       HADDR,
	input  wire logic [1:0]  HTRANS,
	input  wire logic [2:0]  HSIZE,
	input  wire logic        HWRITE,
	input  wire word_t       HWDATA,
	input  wire logic        HREADY,
	input  wire word_t       crc_out,
	input  wire word_t       crc_init_out,
	input  wire word_t       crc_poly_out,
	input  wire logic        buffer_full,
	input  wire logic        reset_pending,
	input  wire logic        read_wait,
	output word_t            HRDATA,
	output logic             HREADYOUT,
	output logic             HRESP,
	output data_item_t       wr_item,
	output logic             buffer_write_en,
	output word_t            bus_wr,
	output crc_cfg_t         cfg,
	output logic             crc_init_en,
	output logic             crc_poly_en,
	output logic             reset_chain
);

	// Address phase copies
	logic [2:0] haddr_pp;
	xfer_size_t hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	byte_t      idr_q;

	logic sample_bus;
	logic xfer_active;
	logic write_en;
	logic read_en;
	logic dr_sel;
	logic dr_write;
	logic dr_read;
	logic init_write;
	logic cr_en;
	logic idr_en;

	// Bus is sampled when the previous data phase ends
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= 2'b00;
			hwrite_pp <= 1'b0;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
			hwrite_pp <= HWRITE;
		end
	end

	// Word offset and transfer size of the sampled transfer
	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp <= HADDR[4:2];
			hsize_pp <= HSIZE[1:0];
		end
	end

	//////////////////////////////////////////////////
	// Data phase decode
	//////////////////////////////////////////////////

	// Only NONSEQ acts, SEQ and BUSY fall through
	assign xfer_active = hselx_pp && (htrans_pp == HTRANS_NONSEQ);
	assign write_en    = xfer_active && hwrite_pp;
	assign read_en     = xfer_active && !hwrite_pp;

	assign dr_sel     = (haddr_pp == ADDR_DR);
	assign dr_write   = dr_sel && write_en;
	assign dr_read    = dr_sel && read_en;
	assign init_write = (haddr_pp == ADDR_INIT) && write_en;
	assign cr_en      = (haddr_pp == ADDR_CR) && write_en;
	assign idr_en     = (haddr_pp == ADDR_IDR) && write_en;

	// A full buffer holds the DR write in its data phase
	assign buffer_write_en = dr_write && !buffer_full;
	// INIT lands only after a pending reload has used the old value
	assign crc_init_en     = init_write && !reset_pending;
	assign crc_poly_en     = (haddr_pp == ADDR_POL) && write_en;
	// CR bit 0 is a one-shot, never stored
	assign reset_chain     = cr_en && HWDATA[0];

	// Write data is taken straight from the bus in the data phase
	assign bus_wr       = HWDATA;
	assign wr_item.data = HWDATA;
	assign wr_item.size = hsize_pp;

	assign HREADYOUT = !((dr_write && buffer_full) ||
	                     (dr_read && read_wait) ||
	                     (init_write && reset_pending));
	// Never an error response
	assign HRESP = 1'b0;

	// CR fields and IDR scratch byte
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			cfg   <= RESET_CR;
			idr_q <= '0;
		end
		else
		begin
			if (cr_en)
				cfg <= crc_cfg_t'(HWDATA[7:3]);
			if (idr_en)
				idr_q <= HWDATA[7:0];
		end
	end

	// Read mux
	always_comb
	begin
		case (haddr_pp)
			ADDR_DR:   HRDATA = crc_out;
			ADDR_IDR:  HRDATA = {24'h0, idr_q};
			// Chain reset bit and bits 2 to 1 read as zero
			ADDR_CR:   HRDATA = {24'h0, cfg, 3'b000};
			ADDR_INIT: HRDATA = crc_init_out;
			ADDR_POL:  HRDATA = crc_poly_out;
			default:   HRDATA = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/crc_pkg.sv ====
/*
 * Shared definitions of the CRC accelerator
 *   Width typedefs for bus words, bytes and control codes
 *   Config and data item structs
 *   Engine state encoding
 *   Register offsets, AHB transfer code, reset values, buffer depth
 */
`default_nettype none

package crc_pkg;

	//////////////////////////////////////////////////
	// Width types
	//////////////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [7:0]  byte_t;
	// 0 is 32 bit, 1 is 16 bit, 2 is 8 bit, 3 is 7 bit
	typedef logic [1:0]  poly_size_t;
	// 0 none, 1 per byte, 2 per halfword, 3 whole word
	typedef logic [1:0]  rev_in_t;
	// Low bits of HSIZE, 0 byte, 1 halfword, 2 word
	typedef logic [1:0]  xfer_size_t;

	// Member order follows CR bits 7 down to 3
	typedef struct packed {
		logic       rev_out;
		rev_in_t    rev_in;
		poly_size_t poly_size;
	} crc_cfg_t;

	// One buffered DR write
	typedef struct packed {
		word_t      data;
		xfer_size_t size;
	} data_item_t;

	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_SHIFT,
		ENG_RELOAD
	} engine_state_t;

	//////////////////////////////////////////////////
	// Register map, word offsets from HADDR[4:2]
	//////////////////////////////////////////////////

	localparam logic [2:0] ADDR_DR   = 3'h0;
	localparam logic [2:0] ADDR_IDR  = 3'h1;
	localparam logic [2:0] ADDR_CR   = 3'h2;
	localparam logic [2:0] ADDR_INIT = 3'h4;
	localparam logic [2:0] ADDR_POL  = 3'h5;

	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	// Reset values
	localparam word_t    RESET_INIT = 32'hFFFF_FFFF;
	localparam word_t    RESET_POLY = 32'h04C1_1DB7;
	localparam crc_cfg_t RESET_CR   = '0;

	localparam int unsigned BUF_DEPTH = 2;

endpackage

`default_nettype wire
